// File: hw/cmd_decoder.sv
module cmd_decoder (
    input  logic                             aclk,
    input  logic                             rst_n,
    input  logic                             head_valid,
    input  logic [raster_pkg::CMD_WIDTH-1:0] head_data,
    input  logic                             color_done,
    input  logic                             depth_done,
    input  logic                             stream_done,
    input  logic                             fb_swapped,
    output logic                             cmd_pop,
    output logic                             scissor_en,
    output raster_pkg::tile_pos_t            scissor_start_x,
    output raster_pkg::tile_pos_t            scissor_start_y,
    output raster_pkg::tile_pos_t            scissor_end_x,
    output raster_pkg::tile_pos_t            scissor_end_y,
    output raster_pkg::pixel_t               color_clear,
    output raster_pkg::pixel_t               depth_clear,
    output logic                             color_memset_start,
    output logic                             depth_memset_start,
    output logic                             color_wr_en,
    output logic                             depth_wr_en,
    output raster_pkg::tile_index_t          wr_index,
    output raster_pkg::pixel_t               wr_data,
    output logic                             stream_start,
    output raster_pkg::buffer_sel_t          stream_sel,
    output logic                             swap_fb
);
    import raster_pkg::*;

    localparam int POS_W = $bits(tile_pos_t);

    decoder_state_t state;
    opcode_t        opcode;
    logic           color_busy;
    logic           depth_busy;
    logic           color_left;
    logic           depth_left;
    logic           swap_pending;

    assign opcode  = opcode_t'(head_data[OPCODE_LSB +: $bits(opcode_t)]);
    // Only pop while idle, which keeps commands strictly in order
    assign cmd_pop = (state == ST_IDLE) && head_valid;

    // Buffers still busy after this cycle's done pulses
    assign color_left = color_busy && !color_done;
    assign depth_left = depth_busy && !depth_done;

    always_ff @(posedge aclk)
    begin
        if (cmd_pop)
        begin
            wr_index <= head_data[WR_INDEX_LSB +: $bits(tile_index_t)];
            wr_data  <= head_data[15:0];
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            state              <= ST_IDLE;
            scissor_en         <= 1'b0;
            scissor_start_x    <= '0;
            scissor_start_y    <= '0;
            scissor_end_x      <= POS_W'(1 << TILE_X_BITS);
            scissor_end_y      <= POS_W'(1 << TILE_Y_BITS);
            color_clear        <= '0;
            depth_clear        <= '0;
            color_memset_start <= 1'b0;
            depth_memset_start <= 1'b0;
            color_wr_en        <= 1'b0;
            depth_wr_en        <= 1'b0;
            stream_start       <= 1'b0;
            stream_sel         <= BUF_COLOR;
            swap_fb            <= 1'b0;
            color_busy         <= 1'b0;
            depth_busy         <= 1'b0;
            swap_pending       <= 1'b0;
        end
        else
        begin
            color_memset_start <= 1'b0;
            depth_memset_start <= 1'b0;
            color_wr_en        <= 1'b0;
            depth_wr_en        <= 1'b0;
            stream_start       <= 1'b0;
            swap_fb            <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (cmd_pop)
                    begin
                        case (opcode)
                            OP_SET_CLEAR_COLOR:
                                color_clear <= rgb888_to_rgb565(head_data[23:0]);
                            OP_SET_CLEAR_DEPTH:
                                depth_clear <= head_data[15:0];
                            OP_SET_SCISSOR:
                            begin
                                scissor_en      <= head_data[SCISSOR_EN_BIT];
                                scissor_start_x <= head_data[SCISSOR_SX_LSB +: POS_W];
                                scissor_start_y <= head_data[SCISSOR_SY_LSB +: POS_W];
                                scissor_end_x   <= head_data[SCISSOR_EX_LSB +: POS_W];
                                scissor_end_y   <= head_data[SCISSOR_EY_LSB +: POS_W];
                            end
                            OP_MEMSET:
                            begin
                                color_memset_start <= head_data[MEMSET_COLOR_BIT];
                                depth_memset_start <= head_data[MEMSET_DEPTH_BIT];
                                color_busy         <= head_data[MEMSET_COLOR_BIT];
                                depth_busy         <= head_data[MEMSET_DEPTH_BIT];
                                if (head_data[MEMSET_COLOR_BIT] || head_data[MEMSET_DEPTH_BIT])
                                    state <= ST_MEMSET;
                            end
                            OP_WRITE_COLOR:
                                color_wr_en <= 1'b1;
                            OP_WRITE_DEPTH:
                                depth_wr_en <= 1'b1;
                            OP_SWAP:
                            begin
                                stream_start <= 1'b1;
                                stream_sel   <= BUF_COLOR;
                                swap_pending <= 1'b1;
                                state        <= ST_STREAM;
                            end
                            OP_DUMP_DEPTH:
                            begin
                                stream_start <= 1'b1;
                                stream_sel   <= BUF_DEPTH;
                                swap_pending <= 1'b0;
                                state        <= ST_STREAM;
                            end
                            default:
                                ;
                        endcase
                    end
                end
                ST_MEMSET:
                begin
                    color_busy <= color_left;
                    depth_busy <= depth_left;
                    if (!color_left && !depth_left)
                        state <= ST_IDLE;
                end
                ST_STREAM:
                begin
                    // Last word has left the stream unit
                    if (stream_done)
                    begin
                        swap_fb <= swap_pending;
                        state   <= swap_pending ? ST_SWAP_WAIT : ST_IDLE;
                    end
                end
                ST_SWAP_WAIT:
                begin
                    if (fb_swapped)
                        state <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: hw/cmd_fifo.sv
module cmd_fifo #(
    parameter int CMD_FIFO_DEPTH = 4
) (
    input  logic                             aclk,
    input  logic                             rst_n,
    input  logic                             cmd_valid,
    input  logic [raster_pkg::CMD_WIDTH-1:0] cmd_data,
    input  logic                             cmd_pop,
    output logic                             head_valid,
    output logic [raster_pkg::CMD_WIDTH-1:0] head_data,
    output logic                             cmd_credit
);
    import raster_pkg::*;

    localparam int PTR_W = (CMD_FIFO_DEPTH > 1) ? $clog2(CMD_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_FIFO_DEPTH + 1);

    logic [CMD_WIDTH-1:0] mem [CMD_FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_data  = mem[rd_ptr];

    // Sender only writes while it holds a credit, so no full check here
    always_ff @(posedge aclk)
    begin
        if (cmd_valid)
            mem[wr_ptr] <= cmd_data;
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            if (cmd_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (cmd_pop)
                rd_ptr <= next_ptr(rd_ptr);
            count      <= count + CNT_W'(cmd_valid) - CNT_W'(cmd_pop);
            // One credit back per popped word
            cmd_credit <= cmd_pop;
        end
    end

endmodule

// File: hw/fb_stream_out.sv
module fb_stream_out #(
    parameter int FB_CREDITS = 2
) (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    stream_start,
    input  raster_pkg::buffer_sel_t stream_sel,
    input  raster_pkg::pixel_t      color_rd_data,
    input  raster_pkg::pixel_t      depth_rd_data,
    input  logic                    fb_credit,
    output raster_pkg::tile_index_t rd_index,
    output logic                    stream_done,
    output logic                    fb_valid,
    output logic                    fb_last,
    output raster_pkg::pixel_t      fb_data
);
    import raster_pkg::*;

    localparam int CNT_W = $clog2(FB_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic [CNT_W-1:0] in_flight;
    logic             active;
    buffer_sel_t      sel;
    tile_index_t      issue_idx;
    logic             issue;
    logic             s1_valid;
    logic             s1_last;

    assign rd_index = issue_idx;
    // Every word in the read pipeline already holds one of the credits
    assign issue = active && ((credit_cnt - in_flight) != '0);

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            credit_cnt  <= CNT_W'(FB_CREDITS);
            in_flight   <= '0;
            active      <= 1'b0;
            sel         <= BUF_COLOR;
            issue_idx   <= '0;
            s1_valid    <= 1'b0;
            s1_last     <= 1'b0;
            fb_valid    <= 1'b0;
            fb_last     <= 1'b0;
            stream_done <= 1'b0;
        end
        else
        begin
            credit_cnt <= credit_cnt + CNT_W'(fb_credit) - CNT_W'(fb_valid);
            in_flight  <= in_flight + CNT_W'(issue) - CNT_W'(fb_valid);
            if (stream_start)
            begin
                active    <= 1'b1;
                issue_idx <= '0;
                sel       <= stream_sel;
            end
            else if (issue)
            begin
                issue_idx <= issue_idx + 1'b1;
                if (issue_idx == tile_index_t'(TILE_PIXELS - 1))
                    active <= 1'b0;
            end
            // Stage 1 waits for the buffer read, stage 2 drives the stream
            s1_valid    <= issue;
            s1_last     <= issue && (issue_idx == tile_index_t'(TILE_PIXELS - 1));
            fb_valid    <= s1_valid;
            fb_last     <= s1_last;
            stream_done <= fb_valid && fb_last;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (s1_valid)
            fb_data <= (sel == BUF_COLOR) ? color_rd_data : depth_rd_data;
    end

endmodule

// File: hw/raster_fb_top.sv
module raster_fb_top #(
    parameter int CMD_FIFO_DEPTH = 4,
    parameter int FB_CREDITS     = 2
) (
    input  logic                             aclk,
    input  logic                             rst_n,
    input  logic                             cmd_valid,
    input  logic [raster_pkg::CMD_WIDTH-1:0] cmd_data,
    output logic                             cmd_credit,
    input  logic                             fb_credit,
    output logic                             fb_valid,
    output logic                             fb_last,
    output raster_pkg::pixel_t               fb_data,
    output logic                             swap_fb,
    input  logic                             fb_swapped
);
    import raster_pkg::*;

    logic                 head_valid;
    logic [CMD_WIDTH-1:0] head_data;
    logic                 cmd_pop;
    logic                 scissor_en;
    tile_pos_t            scissor_start_x;
    tile_pos_t            scissor_start_y;
    tile_pos_t            scissor_end_x;
    tile_pos_t            scissor_end_y;
    pixel_t               color_clear;
    pixel_t               depth_clear;
    logic                 color_memset_start;
    logic                 depth_memset_start;
    logic                 color_memset_done;
    logic                 depth_memset_done;
    logic                 color_wr_en;
    logic                 depth_wr_en;
    tile_index_t          wr_index;
    pixel_t               wr_data;
    logic                 stream_start;
    buffer_sel_t          stream_sel;
    logic                 stream_done;
    tile_index_t          rd_index;
    pixel_t               color_rd_data;
    pixel_t               depth_rd_data;

    cmd_fifo #(
        .CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
    ) cmd_fifo_inst (.*);

    cmd_decoder cmd_decoder_inst (
        .color_done(color_memset_done),
        .depth_done(depth_memset_done),
        .*
    );

    // Both buffers share scissor, write address and read address
    tile_buffer color_buffer (
        .clear_value (color_clear),
        .memset_start(color_memset_start),
        .wr_en       (color_wr_en),
        .memset_done (color_memset_done),
        .rd_data     (color_rd_data),
        .*
    );

    tile_buffer depth_buffer (
        .clear_value (depth_clear),
        .memset_start(depth_memset_start),
        .wr_en       (depth_wr_en),
        .memset_done (depth_memset_done),
        .rd_data     (depth_rd_data),
        .*
    );

    fb_stream_out #(
        .FB_CREDITS(FB_CREDITS)
    ) fb_stream_out_inst (.*);

endmodule

// File: hw/raster_pkg.sv
package raster_pkg;

    // Tile geometry, one 8x8 tile
    localparam int TILE_X_BITS = 3;
    localparam int TILE_Y_BITS = 3;
    localparam int TILE_PIXELS = 1 << (TILE_X_BITS + TILE_Y_BITS);

    localparam int CMD_WIDTH = 32;

    // Pixel index is y * 8 + x
    typedef logic [TILE_X_BITS+TILE_Y_BITS-1:0] tile_index_t;
    // Scissor coordinate 0 to 8, end exclusive
    typedef logic [TILE_X_BITS:0] tile_pos_t;
    // RGB565 color or 16 bit depth
    typedef logic [15:0] pixel_t;

    typedef enum logic [3:0] {
        OP_NOP             = 4'h0,
        OP_SET_CLEAR_COLOR = 4'h1,
        OP_SET_CLEAR_DEPTH = 4'h2,
        OP_SET_SCISSOR     = 4'h3,
        OP_MEMSET          = 4'h4,
        OP_WRITE_COLOR     = 4'h5,
        OP_WRITE_DEPTH     = 4'h6,
        OP_SWAP            = 4'h7,
        OP_DUMP_DEPTH      = 4'h8
    } opcode_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MEMSET,
        ST_STREAM,
        ST_SWAP_WAIT
    } decoder_state_t;

    typedef enum logic {
        BUF_COLOR,
        BUF_DEPTH
    } buffer_sel_t;

    // Command word field positions
    localparam int OPCODE_LSB       = 28;
    localparam int SCISSOR_EN_BIT   = 16;
    localparam int SCISSOR_SX_LSB   = 12;
    localparam int SCISSOR_SY_LSB   = 8;
    localparam int SCISSOR_EX_LSB   = 4;
    localparam int SCISSOR_EY_LSB   = 0;
    localparam int WR_INDEX_LSB     = 16;
    localparam int MEMSET_COLOR_BIT = 0;
    localparam int MEMSET_DEPTH_BIT = 1;

    // Truncate each channel to its upper bits
    function automatic pixel_t rgb888_to_rgb565(input logic [23:0] rgb);
        return {rgb[23:19], rgb[15:10], rgb[7:3]};
    endfunction

endpackage

// File: hw/tile_buffer.sv
module tile_buffer (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    scissor_en,
    input  raster_pkg::tile_pos_t   scissor_start_x,
    input  raster_pkg::tile_pos_t   scissor_start_y,
    input  raster_pkg::tile_pos_t   scissor_end_x,
    input  raster_pkg::tile_pos_t   scissor_end_y,
    input  raster_pkg::pixel_t      clear_value,
    input  logic                    memset_start,
    input  logic                    wr_en,
    input  raster_pkg::tile_index_t wr_index,
    input  raster_pkg::pixel_t      wr_data,
    input  raster_pkg::tile_index_t rd_index,
    output logic                    memset_done,
    output raster_pkg::pixel_t      rd_data
);
    import raster_pkg::*;

    pixel_t      mem [TILE_PIXELS];
    logic        memset_active;
    tile_index_t memset_idx;
    logic        memset_hit;
    logic        wr_hit;

    // Scissor test, start inclusive and end exclusive
    function automatic logic in_scissor(input tile_index_t idx);
        tile_pos_t x;
        tile_pos_t y;
        x = tile_pos_t'(idx[TILE_X_BITS-1:0]);
        y = tile_pos_t'(idx[TILE_X_BITS +: TILE_Y_BITS]);
        return !scissor_en ||
               (x >= scissor_start_x && x < scissor_end_x &&
                y >= scissor_start_y && y < scissor_end_y);
    endfunction

    assign memset_hit = memset_active && in_scissor(memset_idx);
    assign wr_hit     = wr_en && in_scissor(wr_index);

    always_ff @(posedge aclk)
    begin
        if (memset_hit)
            mem[memset_idx] <= clear_value;
        else if (wr_hit)
            mem[wr_index] <= wr_data;
        rd_data <= mem[rd_index];
    end

    // Memset walks every index once, one per cycle
    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            memset_active <= 1'b0;
            memset_idx    <= '0;
            memset_done   <= 1'b0;
        end
        else
        begin
            memset_done <= memset_active && (memset_idx == tile_index_t'(TILE_PIXELS - 1));
            if (memset_start)
            begin
                memset_active <= 1'b1;
                memset_idx    <= '0;
            end
            else if (memset_active)
            begin
                memset_idx <= memset_idx + 1'b1;
                if (memset_idx == tile_index_t'(TILE_PIXELS - 1))
                    memset_active <= 1'b0;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module raster_fb_tb -f sim.f -o raster_fb_sim \
    && ./obj_dir/raster_fb_sim | grep -F "Done: no errors" \
    || { echo "Simulation failed"; exit 1; }

// File: sim.f
hw/raster_pkg.sv
hw/cmd_fifo.sv
hw/cmd_decoder.sv
hw/tile_buffer.sv
hw/fb_stream_out.sv
hw/raster_fb_top.sv
verif/tb_clock_gen.sv
verif/raster_fb_assert.sv
verif/raster_fb_tb.sv

// File: verif/raster_fb_assert.sv
module raster_fb_assert #(
    parameter int FB_CREDITS = 2,
    parameter int CNT_W      = 2
) (
    input logic             aclk,
    input logic             rst_n,
    input logic             fb_valid,
    input logic [CNT_W-1:0] credit_cnt,
    input logic             swap_fb
);
    timeunit 1ns;
    timeprecision 1ps;

    // A word may only leave while a credit is held
    valid_needs_credit: assert property (@(posedge aclk) disable iff (!rst_n)
        fb_valid |-> (credit_cnt != '0))
        else $error("fb_valid asserted with zero credits");

    swap_single_cycle: assert property (@(posedge aclk) disable iff (!rst_n)
        swap_fb |=> !swap_fb)
        else $error("swap_fb held for more than one cycle");

    credit_bound: assert property (@(posedge aclk) disable iff (!rst_n)
        int'(credit_cnt) <= FB_CREDITS)
        else $error("credit count above FB_CREDITS");

endmodule

bind fb_stream_out raster_fb_assert #(
    .FB_CREDITS(FB_CREDITS),
    .CNT_W     (CNT_W)
) stream_assert_inst (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .fb_valid  (fb_valid),
    .credit_cnt(credit_cnt),
    .swap_fb   (1'b0)
);

bind cmd_decoder raster_fb_assert #(
    .FB_CREDITS(1),
    .CNT_W     (1)
) decoder_assert_inst (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .fb_valid  (1'b0),
    .credit_cnt(1'b0),
    .swap_fb   (swap_fb)
);

// File: verif/raster_fb_tb.sv
module raster_fb_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CMD_FIFO_DEPTH = 4;
    localparam int FB_CREDITS     = 2;
    localparam int TIMEOUT        = 500;
    localparam int STREAM_TIMEOUT = 64 * TIMEOUT;
    localparam int NUM_ROWS       = 16;

    typedef struct packed {
        logic [31:0] cmd;
        logic        is_stream;
        logic [5:0]  check_idx;
        logic [15:0] expected;
    } row_t;

    logic        aclk;
    logic        rst_n;
    logic        cmd_valid = 1'b0;
    logic [31:0] cmd_data = 32'h0;
    logic        cmd_credit;
    logic        fb_credit = 1'b0;
    logic        fb_valid;
    logic        fb_last;
    logic [15:0] fb_data;
    logic        swap_fb;
    logic        fb_swapped = 1'b0;

    row_t        rows [NUM_ROWS];
    int          sent = 0;
    int          credits_back = 0;
    int          swap_count = 0;
    int          owed = 0;
    int          credit_delay = 0;
    int          swap_delay = 0;
    int          sent_at_raise = 0;
    integer      seed = 32'h4934291b;

    // Reference tile contents and configuration
    logic [15:0] color_model [64];
    logic [15:0] depth_model [64];
    logic [15:0] color_clear_m = 16'h0;
    logic [15:0] depth_clear_m = 16'h0;
    logic        sc_en = 1'b0;
    int          sc_sx = 0;
    int          sc_sy = 0;
    int          sc_ex = 8;
    int          sc_ey = 8;

    // Stream being collected, captured when its command is sent
    logic        collecting = 1'b0;
    logic        stream_is_swap = 1'b0;
    int          stream_check_idx = 0;
    logic [15:0] stream_expected = 16'h0;
    logic [15:0] stream_ref [64];

    tb_clock_gen clock_gen_inst (
        .aclk (aclk),
        .rst_n(rst_n)
    );

    raster_fb_top #(
        .CMD_FIFO_DEPTH(CMD_FIFO_DEPTH),
        .FB_CREDITS    (FB_CREDITS)
    ) raster_fb_top_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_data  (cmd_data),
        .cmd_credit(cmd_credit),
        .fb_credit (fb_credit),
        .fb_valid  (fb_valid),
        .fb_last   (fb_last),
        .fb_data   (fb_data),
        .swap_fb   (swap_fb),
        .fb_swapped(fb_swapped)
    );

    always @(negedge aclk)
    begin
        if (cmd_credit)
            credits_back <= credits_back + 1;
    end

    // Sink gives credits back one at a time after a random gap
    always @(negedge aclk)
    begin
        fb_credit <= 1'b0;
        if (fb_valid)
            owed = owed + 1;
        if (credit_delay > 0)
            credit_delay = credit_delay - 1;
        else if (owed > 0)
        begin
            fb_credit <= 1'b1;
            owed = owed - 1;
            credit_delay = $unsigned($random(seed)) % 8;
        end
    end

    // Display side answers a swap a few cycles later
    always @(negedge aclk)
    begin
        if (!rst_n)
        begin
            fb_swapped <= 1'b0;
            swap_delay = 0;
        end
        else if (swap_fb)
        begin
            swap_count <= swap_count + 1;
            swap_delay = 3;
        end
        else if (swap_delay > 0)
        begin
            swap_delay = swap_delay - 1;
            if (swap_delay == 0)
            begin
                fb_swapped <= 1'b1;
                sent_at_raise = sent;
            end
        end
        else if (fb_swapped && sent != sent_at_raise)
            fb_swapped <= 1'b0;
    end

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_timeout(input string msg);
        $display("Timed out waiting for %s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    function automatic logic inside_scissor(input int idx);
        int x;
        int y;
        x = idx % 8;
        y = idx / 8;
        return !sc_en || (x >= sc_sx && x < sc_ex && y >= sc_sy && y < sc_ey);
    endfunction

    task automatic update_model(input logic [31:0] cmd);
        int idx;
        int red;
        int green;
        int blue;
        idx = int'(cmd[21:16]);
        case (cmd[31:28])
            4'h1:
            begin
                // Keep 5, 6 and 5 upper bits of red, green and blue
                red   = int'(cmd[23:16]);
                green = int'(cmd[15:8]);
                blue  = int'(cmd[7:0]);
                color_clear_m = 16'((red / 8) * 2048 + (green / 4) * 32 + blue / 8);
            end
            4'h2: depth_clear_m = cmd[15:0];
            4'h3:
            begin
                sc_en = cmd[16];
                sc_sx = int'(cmd[15:12]);
                sc_sy = int'(cmd[11:8]);
                sc_ex = int'(cmd[7:4]);
                sc_ey = int'(cmd[3:0]);
            end
            4'h4:
            begin
                for (int i = 0; i < 64; i++)
                begin
                    if (inside_scissor(i) && cmd[0])
                        color_model[i] = color_clear_m;
                    if (inside_scissor(i) && cmd[1])
                        depth_model[i] = depth_clear_m;
                end
            end
            4'h5:
                if (inside_scissor(idx))
                    color_model[idx] = cmd[15:0];
            4'h6:
                if (inside_scissor(idx))
                    depth_model[idx] = cmd[15:0];
            default:
                ;
        endcase
    endtask

    task automatic send_cmd(input logic [31:0] word);
        int waited;
        waited = 0;
        @(negedge aclk);
        // A credit can be held back behind a whole stream
        while (CMD_FIFO_DEPTH - sent + credits_back == 0)
        begin
            waited++;
            if (waited > STREAM_TIMEOUT)
                report_timeout("a command credit");
            @(negedge aclk);
        end
        cmd_valid = 1'b1;
        cmd_data  = word;
        sent      = sent + 1;
        @(negedge aclk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_stream_idle();
        int waited;
        waited = 0;
        while (collecting)
        begin
            waited++;
            if (waited > STREAM_TIMEOUT)
                report_timeout("the previous stream to finish");
            @(negedge aclk);
        end
    endtask

    task automatic collect_stream();
        int          word;
        int          waited;
        int          swaps_before;
        logic [15:0] ref_val;
        word = 0;
        swaps_before = swap_count;
        while (word < 64)
        begin
            waited = 0;
            @(negedge aclk);
            while (!fb_valid)
            begin
                waited++;
                if (waited > TIMEOUT)
                    report_timeout($sformatf("stream word %0d", word));
                @(negedge aclk);
            end
            ref_val = stream_ref[word];
            assert (fb_data == ref_val)
            else
                report_error($sformatf("word %0d is %h, expected %h", word, fb_data, ref_val));
            assert (fb_last == (word == 63))
            else
                report_error($sformatf("fb_last is %b at word %0d", fb_last, word));
            if (word == stream_check_idx)
            begin
                assert (fb_data == stream_expected)
                else
                    report_error($sformatf("index %0d is %h, table says %h",
                                           word, fb_data, stream_expected));
            end
            assert (swap_count == swaps_before)
            else
                report_error("swap_fb pulsed before the last word");
            word++;
        end
        if (stream_is_swap)
        begin
            waited = 0;
            while (swap_count == swaps_before)
            begin
                waited++;
                if (waited > TIMEOUT)
                    report_timeout("swap_fb");
                @(negedge aclk);
            end
        end
        collecting = 1'b0;
    endtask

    initial
    begin
        int waited;
        // Command, stream flag, check index, expected value
        rows[0]  = '{32'h10FF8040, 1'b0, 6'd0,  16'h0000};
        rows[1]  = '{32'h20001234, 1'b0, 6'd0,  16'h0000};
        rows[2]  = '{32'h40000003, 1'b0, 6'd0,  16'h0000};
        rows[3]  = '{32'h70000000, 1'b1, 6'd63, 16'hFC08};
        rows[4]  = '{32'h30012143, 1'b0, 6'd0,  16'h0000};
        rows[5]  = '{32'h2000BEEF, 1'b0, 6'd0,  16'h0000};
        rows[6]  = '{32'h40000002, 1'b0, 6'd0,  16'h0000};
        rows[7]  = '{32'h80000000, 1'b1, 6'd10, 16'hBEEF};
        rows[8]  = '{32'h80000000, 1'b1, 6'd0,  16'h1234};
        rows[9]  = '{32'h500B07E0, 1'b0, 6'd0,  16'h0000};
        rows[10] = '{32'h5028F800, 1'b0, 6'd0,  16'h0000};
        rows[11] = '{32'h00000000, 1'b0, 6'd0,  16'h0000};
        rows[12] = '{32'h70000000, 1'b1, 6'd11, 16'h07E0};
        rows[13] = '{32'h70000000, 1'b1, 6'd40, 16'hFC08};
        rows[14] = '{32'h30000088, 1'b0, 6'd0,  16'h0000};
        rows[15] = '{32'h80000000, 1'b1, 6'd63, 16'h1234};

        waited = 0;
        while (rst_n !== 1'b1)
        begin
            waited++;
            if (waited > TIMEOUT)
                report_timeout("reset release");
            @(negedge aclk);
        end
        @(negedge aclk);
        assert (!cmd_credit && !fb_valid && !fb_last && !swap_fb)
        else
            report_error("outputs active after reset");

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            // Rows after a stream queue behind it, the next stream waits for it
            if (rows[r].is_stream)
                wait_stream_idle();
            update_model(rows[r].cmd);
            send_cmd(rows[r].cmd);
            if (rows[r].is_stream)
            begin
                stream_is_swap   = (rows[r].cmd[31:28] == 4'h7);
                stream_check_idx = int'(rows[r].check_idx);
                stream_expected  = rows[r].expected;
                for (int i = 0; i < 64; i++)
                    stream_ref[i] = stream_is_swap ? color_model[i] : depth_model[i];
                collecting = 1'b1;
                fork
                    collect_stream();
                join_none
            end
        end
        wait_stream_idle();

        // Every word sent must come back as a credit
        waited = 0;
        while (credits_back != sent)
        begin
            waited++;
            if (waited > TIMEOUT)
                report_timeout("the last command credits");
            @(negedge aclk);
        end
        @(negedge aclk);
        if (credits_back == sent && swap_count == 3)
        begin
            $display("Done: no errors");
            $finish;
        end
        else
        begin
            $display("Error at %0t ns: %0d credits for %0d words, %0d swaps",
                     $time, credits_back, sent, swap_count);
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen (
    output logic aclk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        aclk = 1'b0;
        forever
            #10 aclk = ~aclk;
    end

    // Reset held for 10 cycles, released on a falling edge
    initial
    begin
        rst_n = 1'b0;
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
    end

endmodule
